// File: verilog/loader_pkg.sv
package loader_pkg;

    // Program ROM geometry.
    localparam int ROM_ADDR_W = 14;
    localparam int ROM_DATA_W = 32;

    typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
    typedef logic [ROM_DATA_W-1:0] rom_word_t;

    // Serial receiver FSM.
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    // Loader FSM: length header first, then the image bytes.
    typedef enum logic {
        LOAD_LEN,
        LOAD_DATA
    } load_state_t;

endpackage

// File: verilog/uart_receiver.sv
`timescale 1ns/1ps

module uart_receiver #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       frame_error
);

    import loader_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int HALF_BIT = CLKS_PER_BIT / 2;

    // The synchronizer and FSM add three cycles between the line and the
    // decision, so the stop bit is judged early to keep rx_valid at its centre.
    localparam int STOP_WAIT = CLKS_PER_BIT - 2;

    rx_state_t        state;
    logic             rxd_meta;
    logic             rxd_sync;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       rx_shift;

    // Two-flop synchronizer, idles high like the line.
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state       <= RX_IDLE;
            bit_cnt     <= '0;
            bit_idx     <= 3'd0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;

            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    bit_idx <= 3'd0;
                    if (!rxd_sync) begin
                        state <= RX_START;
                    end
                end

                RX_START: begin
                    // Confirm the start bit at half a bit time.
                    if (bit_cnt == CNT_W'(HALF_BIT - 1)) begin
                        bit_cnt <= '0;
                        if (!rxd_sync) begin
                            state <= RX_DATA;
                        end else begin
                            state <= RX_IDLE;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                RX_DATA: begin
                    if (bit_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                RX_STOP: begin
                    if (bit_cnt == CNT_W'(STOP_WAIT - 1)) begin
                        bit_cnt <= '0;
                        state   <= RX_IDLE;
                        if (rxd_sync) begin
                            rx_valid <= 1'b1;
                        end else begin
                            frame_error <= 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Data bits arrive LSB first.
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            rx_shift <= {rxd_sync, rx_shift[7:1]};
        end
    end

    assign rx_data = rx_shift;

endmodule

// File: verilog/rom_loader.sv
`timescale 1ns/1ps

module rom_loader (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [7:0]            rx_data,
    input  logic                  rx_valid,
    output logic                  soft_reset,
    output loader_pkg::rom_addr_t write_addr,
    output loader_pkg::rom_word_t write_data,
    output logic                  write_req
);

    import loader_pkg::*;

    load_state_t state;
    load_state_t state_next;

    logic [31:0] len;
    logic [31:0] len_next;
    logic [1:0]  len_idx;
    logic [1:0]  len_idx_next;

    logic [31:0] data_idx;
    logic [31:0] data_idx_next;
    logic [31:0] data_idx_inc;

    rom_addr_t write_addr_next;
    rom_word_t write_data_next;
    logic      write_req_next;

    // The rest of the system is held while the image streams in.
    assign soft_reset = (state == LOAD_DATA);

    assign data_idx_inc = data_idx + 32'd1;

    always_comb begin
        state_next      = state;
        len_next        = len;
        len_idx_next    = len_idx;
        data_idx_next   = data_idx;
        write_addr_next = write_addr;
        write_data_next = write_data;
        write_req_next  = 1'b0;

        case (state)
            LOAD_LEN: begin
                if (rx_valid) begin
                    // Little-endian byte count.
                    len_next = {rx_data, len[31:8]};
                    if (len_idx == 2'd3) begin
                        state_next    = LOAD_DATA;
                        data_idx_next = 32'd0;
                    end else begin
                        len_idx_next = len_idx + 2'd1;
                    end
                end
            end

            LOAD_DATA: begin
                if (rx_valid) begin
                    write_data_next = {rx_data, write_data[31:8]};
                    if (data_idx[1:0] == 2'd3) begin
                        write_addr_next = data_idx[ROM_ADDR_W+1:2];
                        write_req_next  = 1'b1;
                    end

                    data_idx_next = data_idx_inc;
                    if (data_idx_inc == len) begin
                        state_next   = LOAD_LEN;
                        len_idx_next = 2'd0;
                    end
                end
            end

            default: begin
                state_next = LOAD_LEN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= LOAD_LEN;
            len_idx   <= 2'd0;
            data_idx  <= 32'd0;
            write_req <= 1'b0;
        end else begin
            state     <= state_next;
            len_idx   <= len_idx_next;
            data_idx  <= data_idx_next;
            write_req <= write_req_next;
        end
    end

    always_ff @(posedge clk) begin
        len        <= len_next;
        write_addr <= write_addr_next;
        write_data <= write_data_next;
    end

endmodule

// File: verilog/program_rom.sv
`timescale 1ns/1ps

module program_rom #(
    parameter int ROM_WORDS = 16384
) (
    input  logic                  clk,
    input  loader_pkg::rom_addr_t write_addr,
    input  loader_pkg::rom_word_t write_data,
    input  logic                  write_req,
    input  loader_pkg::rom_addr_t read_addr,
    output loader_pkg::rom_word_t read_data
);

    import loader_pkg::*;

    localparam int IDX_W = (ROM_WORDS > 1) ? $clog2(ROM_WORDS) : 1;

    rom_word_t mem [ROM_WORDS];

    logic [IDX_W-1:0] write_idx;
    logic [IDX_W-1:0] read_idx;

    // Upper address bits are dropped, so the array repeats.
    assign write_idx = write_addr[IDX_W-1:0];
    assign read_idx  = read_addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (write_req) begin
            mem[write_idx] <= write_data;
        end
    end

    // Read-first on a same-address collision.
    always_ff @(posedge clk) begin
        read_data <= mem[read_idx];
    end

endmodule

// File: verilog/program_loader_top.sv
`timescale 1ns/1ps

module program_loader_top #(
    parameter int CLKS_PER_BIT = 16,
    parameter int ROM_WORDS    = 16384
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        uart_rxd,
    input  logic [13:0] read_addr,
    output logic [31:0] read_data,
    output logic        soft_reset,
    output logic        frame_error
);

    import loader_pkg::*;

    logic [7:0] rx_data;
    logic       rx_valid;

    rom_addr_t write_addr;
    rom_word_t write_data;
    logic      write_req;

    uart_receiver #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_receiver (
        .clk        (clk),
        .reset_n    (reset_n),
        .rxd        (uart_rxd),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .frame_error(frame_error)
    );

    rom_loader u_rom_loader (
        .clk       (clk),
        .reset_n   (reset_n),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .soft_reset(soft_reset),
        .write_addr(write_addr),
        .write_data(write_data),
        .write_req (write_req)
    );

    program_rom #(
        .ROM_WORDS(ROM_WORDS)
    ) u_program_rom (
        .clk       (clk),
        .write_addr(write_addr),
        .write_data(write_data),
        .write_req (write_req),
        .read_addr (read_addr),
        .read_data (read_data)
    );

endmodule

// File: tests/tb_program_loader.sv
`timescale 1ns/1ps

module tb_program_loader;

    localparam int    CLKS_PER_BIT  = 8;
    localparam int    ROM_WORDS     = 256;
    localparam int    FRAME_BITS    = 10;
    localparam int    MARGIN_CYCLES = 2000;
    localparam int    NEWLINE       = 10;
    localparam string STIM_FILE     = "tests/loader_stim.txt";

    logic        clk;
    logic        reset_n   = 1'b0;
    logic        uart_rxd  = 1'b1;
    logic [13:0] read_addr = 14'd0;
    logic [31:0] read_data;
    logic        soft_reset;
    logic        frame_error;

    int    cycle_count  = 0;
    int    cycle_limit  = 0;
    int    fe_count     = 0;
    int    fe_mark      = 0;
    int    test_checks  = 0;
    int    test_errors  = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    other_errors = 0;
    bit    test_open    = 1'b0;
    string test_name    = "none";

    program_loader_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .ROM_WORDS   (ROM_WORDS)
    ) DUT (
        .clk        (clk),
        .reset_n    (reset_n),
        .uart_rxd   (uart_rxd),
        .read_addr  (read_addr),
        .read_data  (read_data),
        .soft_reset (soft_reset),
        .frame_error(frame_error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Frame error pulses are only one cycle wide, so they are counted here.
    always @(posedge clk) begin
        if (frame_error) begin
            fe_count <= fe_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the stimulus did not finish within %0d clock cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        test_checks = test_checks + 1;
        if (actual !== expected) begin
            test_errors = test_errors + 1;
            $display("[ERROR] %0s: %0s expected %08h, actual %08h",
                     test_name, what, expected, actual);
        end
    endtask

    // A command whose fields do not all parse means the stimulus file is broken.
    task automatic report_missing_fields(input logic [7:0] op, input int got, input int want);
        if (got != want) begin
            other_errors = other_errors + 1;
            $display("Command '%c' in %0s has %0d of %0d fields", op, STIM_FILE, got, want);
        end
    endtask

    task automatic finish_test();
        if (test_open) begin
            if (test_errors == 0) begin
                tests_passed = tests_passed + 1;
                $display("Test %0s: PASS (%0d checks)", test_name, test_checks);
            end else begin
                tests_failed = tests_failed + 1;
                $display("Test %0s: FAIL (%0d of %0d checks wrong)",
                         test_name, test_errors, test_checks);
            end
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic apply_reset();
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    task automatic drive_bit(input logic level, input int cycles);
        @(posedge clk);
        uart_rxd <= level;
        repeat (cycles - 1) @(posedge clk);
    endtask

    // 8N1 frame, LSB first.
    task automatic send_frame(input logic [7:0] data, input bit stop_high);
        drive_bit(1'b0, CLKS_PER_BIT);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i], CLKS_PER_BIT);
        end
        if (stop_high) begin
            drive_bit(1'b1, CLKS_PER_BIT);
        end else begin
            // Low across the stop sample point only, then idle for two bit times
            // so the line is high again before a new start bit could be confirmed.
            drive_bit(1'b0, 5);
            drive_bit(1'b1, 3 + 2 * CLKS_PER_BIT);
        end
    endtask

    task automatic read_word(input logic [13:0] addr, output logic [31:0] word);
        @(posedge clk);
        read_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        word = read_data;
    endtask

    // One pass over the command file; without execute it only counts frames.
    task automatic process_file(input int fd, input bit execute, output int byte_count);
        int               code;
        int               ch;
        logic [7:0]       op;
        logic [31:0]      field_a;
        logic [31:0]      field_b;
        logic [31:0]      word;
        logic [8*32-1:0]  name_buf;
        byte_count = 0;
        while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": begin
                    ch = $fgetc(fd);
                    while (ch != NEWLINE && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                "B": begin
                    code = $fscanf(fd, "%h %h", field_a, field_b);
                    byte_count = byte_count + int'(field_b);
                    if (execute) begin
                        report_missing_fields(op, code, 2);
                        repeat (field_b) send_frame(field_a[7:0], 1'b1);
                    end
                end
                "E": begin
                    code = $fscanf(fd, "%h", field_a);
                    byte_count = byte_count + 1;
                    if (execute) begin
                        report_missing_fields(op, code, 1);
                        send_frame(field_a[7:0], 1'b0);
                    end
                end
                "R": begin
                    code = $fscanf(fd, "%h %h", field_a, field_b);
                    if (execute) begin
                        report_missing_fields(op, code, 2);
                        read_word(field_a[13:0], word);
                        check_value($sformatf("word %0h", field_a[13:0]), field_b, word);
                    end
                end
                "S": begin
                    code = $fscanf(fd, "%h", field_a);
                    if (execute) begin
                        report_missing_fields(op, code, 1);
                        @(negedge clk);
                        check_value("soft_reset", field_a, 32'(soft_reset));
                    end
                end
                "F": begin
                    code = $fscanf(fd, "%h", field_a);
                    if (execute) begin
                        report_missing_fields(op, code, 1);
                        @(negedge clk);
                        check_value("frame_error seen", field_a, 32'(fe_count != fe_mark));
                        fe_mark = fe_count;
                    end
                end
                "T": begin
                    code = $fscanf(fd, "%s", name_buf);
                    if (execute) begin
                        report_missing_fields(op, code, 1);
                        finish_test();
                        test_name = string'(name_buf);
                        test_open = 1'b1;
                    end
                end
                default: begin
                    if (execute) begin
                        other_errors = other_errors + 1;
                        $display("Unknown command '%c' in %0s", op, STIM_FILE);
                    end
                end
            endcase
        end
    endtask

    initial begin
        int fd;
        int stim_bytes;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %0s", STIM_FILE);
            $display("Verification failed");
            $finish;
        end else begin
            process_file(fd, 1'b0, stim_bytes);
            $fclose(fd);
            cycle_limit = stim_bytes * FRAME_BITS * CLKS_PER_BIT + MARGIN_CYCLES;
            fd = $fopen(STIM_FILE, "r");
            apply_reset();
            process_file(fd, 1'b1, stim_bytes);
            $fclose(fd);
            finish_test();
            $display("Tests passed: %0d, failed: %0d, other errors: %0d",
                     tests_passed, tests_failed, other_errors);
            if (tests_failed == 0 && other_errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

// File: tests/loader_stim.txt
# Columns: op field1 field2, fields in hex.
# B byte count | E byte (low stop bit) | R addr word | S soft_reset | F frame_error_seen | T name
T after_reset
S 0
F 0
B 08 1
B 00 2
S 0
B 00 1
S 1
T eight_bytes
B 11 1
B 22 1
B 33 1
B 44 1
B 55 1
B 66 1
B 77 1
B 88 1
S 0
R 0 44332211
R 1 88776655
T short_tail
B 06 1
B 00 3
S 1
B AA 1
B BB 1
B CC 1
B DD 1
B EE 2
S 0
R 0 DDCCBBAA
R 1 88776655
T overwrite_word0
B 04 1
B 00 3
B 12 1
B 34 1
B 56 1
B 78 1
S 0
R 0 78563412
R 1 88776655
T framing_error
E 5A
F 1
B 04 1
B 00 2
S 0
B 00 1
S 1
B C3 4
S 0
F 0
R 0 C3C3C3C3
R 1 88776655
T top_word
B 00 1
B 04 1
B 00 2
S 1
B 5A 3FC
S 1
B 01 1
B 02 1
B 03 1
B 04 1
S 0
R FF 04030201
R FE 5A5A5A5A
R 0 5A5A5A5A

// File: tb.f
verilog/loader_pkg.sv
verilog/uart_receiver.sv
verilog/rom_loader.sv
verilog/program_rom.sv
verilog/program_loader_top.sv
tests/tb_program_loader.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_program_loader
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= Verification passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
